// ==== rtl/lcdPkg.sv ====
`default_nettype none

package lcdPkg;

   // --------------------
   // bus and counter widths
   // --------------------
   typedef logic [3:0]  lcdNibbleT;                 // one value on the 4-bit LCD bus
   typedef logic [7:0]  lcdByteT;                   // command or character code
   typedef logic [19:0] waitCountT;                 // covers the 750k power-on wait

   // --------------------
   // sequencer states
   // --------------------
   typedef enum logic [2:0]
   {
      powerOnWait,                                  // delay after reset release
      initNibble,                                   // one of the 3,3,3,2 nibbles
      initWait,                                     // extra wait after an init nibble
      configByte,                                   // 28, 06, 0C, 01
      clearWait,                                    // display clear settles
      phraseChar,                                   // data write of one character
      done                                          // sequence finished
   } seqStateT;

   // --------------------
   // phrase shown after init
   // --------------------
   localparam int PhraseLength = 10;

   // "Hola Mundo" in ASCII, first character at index 0
   localparam lcdByteT PhraseText [PhraseLength] = '{
      8'h48,                                        // H
      8'h6F,                                        // o
      8'h6C,                                        // l
      8'h61,                                        // a
      8'h20,                                        // space
      8'h4D,                                        // M
      8'h75,                                        // u
      8'h6E,                                        // n
      8'h64,                                        // d
      8'h6F                                         // o
   };

endpackage

`default_nettype wire

// ==== rtl/lcdNibbleWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdNibbleWriter #(
   parameter int EnableCycles = 12,                 // width of the enable pulse
   parameter int NibbleGap    = 50,                 // idle cycles between nibbles
   parameter int CommandWait  = 2000                // settle time after the last nibble
) (
   input  wire              Clock,
   input  wire              rstN,
   input  wire              writeStart,             // one-cycle request
   input  wire lcdPkg::lcdByteT writeByte,          // command or character
   input  wire              nibbleOnly,             // send only writeByte[3:0]
   input  wire              isData,                 // register select for this write
   output logic             writeDone,              // one-cycle completion pulse
   output lcdPkg::lcdNibbleT lcdData,
   output logic             lcdEnable,
   output logic             lcdRegisterSelect
);

   // --------------------
   // local state machine
   // --------------------
   typedef enum logic [2:0]
   {
      idle,                                         // waiting for writeStart
      setup,                                        // data and RS valid, enable low
      enableHigh,                                   // enable pulse
      hold,                                         // data held after enable falls
      gap,                                          // pause before the low nibble
      postWait                                      // command execution time
   } writerStateT;

   writerStateT       state;
   lcdPkg::waitCountT count;                        // shared down counter
   logic              onLowNibble;                  // current nibble is the last one
   lcdPkg::lcdByteT   heldByte;                     // byte latched at start

   assign lcdEnable = (state == enableHigh);        // straight decode of a register

   // byte kept for the low nibble
   always_ff @(posedge Clock)
   begin
      if (writeStart)
         heldByte <= writeByte;
   end

   always_ff @(posedge Clock or negedge rstN)
   begin
      if (!rstN)
      begin
         state             <= idle;
         count             <= '0;
         onLowNibble       <= 1'b0;
         writeDone         <= 1'b0;
         lcdData           <= '0;
         lcdRegisterSelect <= 1'b0;
      end
      else
      begin
         writeDone <= 1'b0;                         // pulse unless set below
         case (state)
            idle:
            begin
               if (writeStart)
               begin
                  onLowNibble       <= nibbleOnly;  // init nibbles skip the high half
                  lcdData           <= nibbleOnly ? writeByte[3:0] : writeByte[7:4];
                  lcdRegisterSelect <= isData;
                  state             <= setup;
               end
            end
            setup:
            begin
               count <= lcdPkg::waitCountT'(EnableCycles - 1);
               state <= enableHigh;
            end
            enableHigh:
            begin
               if (count == '0)
                  state <= hold;
               else
                  count <= count - 1'b1;
            end
            hold:
            begin
               if (!onLowNibble)
               begin
                  onLowNibble <= 1'b1;              // low nibble comes next
                  if (NibbleGap == 0)
                  begin
                     lcdData <= heldByte[3:0];
                     state   <= setup;
                  end
                  else
                  begin
                     count <= lcdPkg::waitCountT'(NibbleGap - 1);
                     state <= gap;
                  end
               end
               else if (CommandWait == 0)
               begin
                  writeDone <= 1'b1;
                  state     <= idle;
               end
               else
               begin
                  count <= lcdPkg::waitCountT'(CommandWait - 1);
                  state <= postWait;
               end
            end
            gap:
            begin
               if (count == '0)
               begin
                  lcdData <= heldByte[3:0];         // new data one cycle before enable
                  state   <= setup;
               end
               else
                  count <= count - 1'b1;
            end
            postWait:
            begin
               if (count == '0)
               begin
                  writeDone <= 1'b1;                // lines up with the return to idle
                  state     <= idle;
               end
               else
                  count <= count - 1'b1;
            end
            default:
               state <= idle;
         endcase
      end
   end

   // --------------------
   // checks
   // --------------------
   // every pulse is exactly EnableCycles cycles wide
   enablePulseWidth: assert property (@(posedge Clock) disable iff (!rstN)
      $fell(lcdEnable) |-> $past(lcdEnable, EnableCycles) && !$past(lcdEnable, EnableCycles + 1))
      else $error("lcdEnable pulse is not EnableCycles wide");

   // sequencer must wait for writeDone before the next request
   startOnlyWhenIdle: assert property (@(posedge Clock) disable iff (!rstN)
      writeStart |-> state == idle)
      else $error("writeStart while the writer is busy");

endmodule

`default_nettype wire

// ==== rtl/lcdSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdSequencer #(
   parameter int PowerOnWait  = 750000,             // counted from reset release
   parameter int InitLongWait = 205000,             // after the first init nibble
   parameter int InitMidWait  = 5000,               // after the second init nibble
   parameter int ClearWait    = 82000               // after the clear command
) (
   input  wire              Clock,
   input  wire              rstN,
   input  wire              writeDone,              // from the writer
   output logic             writeStart,             // one-cycle request
   output lcdPkg::lcdByteT  writeByte,
   output logic             nibbleOnly,
   output logic             isData,
   output logic             initDone                // stays high once set
);

   localparam int LastInitStep   = 3;               // four init nibbles
   localparam int LastConfigStep = 3;               // four config bytes

   lcdPkg::seqStateT  state;
   logic [3:0]        stepIndex;                    // nibble, byte or character index
   lcdPkg::waitCountT timer;                        // reloaded for each wait
   logic              writePending;                 // request out, no writeDone yet
   logic              issueWrite;
   lcdPkg::lcdByteT   nextByte;
   lcdPkg::waitCountT initExtraWait;

   // --------------------
   // request decode
   // --------------------
   assign issueWrite = !writePending && (state == lcdPkg::initNibble ||
                                         state == lcdPkg::configByte ||
                                         state == lcdPkg::phraseChar);

   always_comb
   begin
      case (state)
         lcdPkg::initNibble:
            nextByte = (stepIndex == 4'(LastInitStep)) ? 8'h02 : 8'h03;
         lcdPkg::configByte:
         begin
            case (stepIndex[1:0])
               2'd0:    nextByte = 8'h28;           // 4-bit bus, two lines
               2'd1:    nextByte = 8'h06;           // entry mode, increment
               2'd2:    nextByte = 8'h0C;           // display on, no cursor
               default: nextByte = 8'h01;           // clear display
            endcase
         end
         lcdPkg::phraseChar:
            nextByte = lcdPkg::PhraseText[stepIndex];
         default:
            nextByte = '0;
      endcase
   end

   // writer CommandWait already covers the last two nibbles
   always_comb
   begin
      case (stepIndex)
         4'd0:    initExtraWait = lcdPkg::waitCountT'(InitLongWait);
         4'd1:    initExtraWait = lcdPkg::waitCountT'(InitMidWait);
         default: initExtraWait = '0;
      endcase
   end

   // payload to the writer, latched there on writeStart
   always_ff @(posedge Clock)
   begin
      if (issueWrite)
      begin
         writeByte  <= nextByte;
         nibbleOnly <= (state == lcdPkg::initNibble);
         isData     <= (state == lcdPkg::phraseChar);
      end
   end

   // --------------------
   // main sequence
   // --------------------
   always_ff @(posedge Clock or negedge rstN)
   begin
      if (!rstN)
      begin
         state        <= lcdPkg::powerOnWait;
         stepIndex    <= '0;
         timer        <= lcdPkg::waitCountT'(PowerOnWait);  // starts at release
         writePending <= 1'b0;
         writeStart   <= 1'b0;
         initDone     <= 1'b0;
      end
      else
      begin
         writeStart <= 1'b0;
         if (issueWrite)
         begin
            writeStart   <= 1'b1;
            writePending <= 1'b1;
         end
         else if (writeDone)
            writePending <= 1'b0;                   // next write may go out

         case (state)
            lcdPkg::powerOnWait:
            begin
               if (timer == '0)
                  state <= lcdPkg::initNibble;
               else
                  timer <= timer - 1'b1;
            end
            lcdPkg::initNibble:
            begin
               if (writeDone)
               begin
                  timer <= initExtraWait;           // counted from next cycle
                  state <= lcdPkg::initWait;
               end
            end
            lcdPkg::initWait:
            begin
               if (timer != '0)
                  timer <= timer - 1'b1;
               else if (stepIndex == 4'(LastInitStep))
               begin
                  stepIndex <= '0;
                  state     <= lcdPkg::configByte;
               end
               else
               begin
                  stepIndex <= stepIndex + 1'b1;
                  state     <= lcdPkg::initNibble;
               end
            end
            lcdPkg::configByte:
            begin
               if (writeDone)
               begin
                  if (stepIndex == 4'(LastConfigStep))
                  begin
                     stepIndex <= '0;
                     timer     <= lcdPkg::waitCountT'(ClearWait);
                     state     <= lcdPkg::clearWait;
                  end
                  else
                     stepIndex <= stepIndex + 1'b1;
               end
            end
            lcdPkg::clearWait:
            begin
               if (timer == '0)
                  state <= lcdPkg::phraseChar;
               else
                  timer <= timer - 1'b1;
            end
            lcdPkg::phraseChar:
            begin
               if (writeDone)
               begin
                  if (stepIndex == 4'(lcdPkg::PhraseLength - 1))
                  begin
                     initDone <= 1'b1;              // last character written
                     state    <= lcdPkg::done;
                  end
                  else
                     stepIndex <= stepIndex + 1'b1;
               end
            end
            lcdPkg::done:
               state <= lcdPkg::done;               // park until reset
            default:
               state <= lcdPkg::powerOnWait;
         endcase
      end
   end

   // --------------------
   // checks
   // --------------------
   // done only once the last write closed, and no request follows
   initDoneSticky: assert property (@(posedge Clock) disable iff (!rstN)
      initDone |=> initDone && !writeStart && !writePending)
      else $error("initDone dropped or a write followed it");

endmodule

`default_nettype wire

// ==== rtl/lcdController.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdController #(
   // defaults for a 50 MHz clock
   parameter int EnableCycles = 12,                 // 240 ns enable pulse
   parameter int NibbleGap    = 50,                 // 1 us between nibbles
   parameter int CommandWait  = 2000,               // 40 us per command
   parameter int PowerOnWait  = 750000,             // 15 ms
   parameter int InitLongWait = 205000,             // 4.1 ms
   parameter int InitMidWait  = 5000,               // 100 us
   parameter int ClearWait    = 82000               // 1.64 ms
) (
   input  wire                    Clock,
   input  wire                    rstN,
   output wire lcdPkg::lcdNibbleT lcdData,
   output wire                    lcdEnable,
   output wire                    lcdRegisterSelect,
   output wire                    initDone
);

   // sequencer to writer
   wire                  writeStart;
   wire lcdPkg::lcdByteT writeByte;
   wire                  nibbleOnly;
   wire                  isData;
   wire                  writeDone;

   lcdSequencer #(
      .PowerOnWait  (PowerOnWait),
      .InitLongWait (InitLongWait),
      .InitMidWait  (InitMidWait),
      .ClearWait    (ClearWait)
   ) sequencer (
      .Clock      (Clock),
      .rstN       (rstN),
      .writeDone  (writeDone),
      .writeStart (writeStart),
      .writeByte  (writeByte),
      .nibbleOnly (nibbleOnly),
      .isData     (isData),
      .initDone   (initDone)
   );

   lcdNibbleWriter #(
      .EnableCycles (EnableCycles),
      .NibbleGap    (NibbleGap),
      .CommandWait  (CommandWait)
   ) writer (
      .Clock             (Clock),
      .rstN              (rstN),
      .writeStart        (writeStart),
      .writeByte         (writeByte),
      .nibbleOnly        (nibbleOnly),
      .isData            (isData),
      .writeDone         (writeDone),
      .lcdData           (lcdData),
      .lcdEnable         (lcdEnable),
      .lcdRegisterSelect (lcdRegisterSelect)
   );

endmodule

`default_nettype wire

// ==== test/lcdBusMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdBusMonitor #(
   parameter int EnableCycles = 12,
   parameter int PowerOnWait  = 750000,
   parameter int InitLongWait = 205000,
   parameter int ClearWait    = 82000
) (
   input  wire                    Clock,
   input  wire                    rstN,
   input  wire lcdPkg::lcdNibbleT lcdData,
   input  wire                    lcdEnable,
   input  wire                    lcdRegisterSelect,
   input  wire                    initDone,
   output wire                    checkFailed           // high from the first bad check
);

   localparam int PulseCount       = 32;                 // 4 init + 8 config + 20 phrase
   localparam int FirstConfigPulse = 4;
   localparam int FirstPhrasePulse = 12;

   localparam lcdPkg::lcdByteT ConfigBytes [4] = '{8'h28, 8'h06, 8'h0C, 8'h01};

   lcdPkg::lcdNibbleT expNibble [PulseCount];
   logic              expSelect [PulseCount];
   logic              errorSeen = 1'b0;
   logic              prevRstN = 1'b0;
   logic              prevEnable = 1'b0;
   int                pulseIndex;                        // pulses since last release
   int                highCount;                         // samples with enable high
   int                sinceRelease;
   int                sinceFall;                         // low samples after last pulse
   lcdPkg::lcdNibbleT pulseData;                         // bus value at the rising sample
   logic              pulseSelect;

   assign checkFailed = errorSeen;

   // --------------------
   // expected nibble stream
   // --------------------
   initial
   begin : buildExpected
      for (int i = 0; i < 4; i++)
      begin
         expNibble[i] = (i == 3) ? 4'h2 : 4'h3;          // 3, 3, 3, 2
         expSelect[i] = 1'b0;
      end
      for (int i = 0; i < 4; i++)
      begin
         expNibble[FirstConfigPulse + 2 * i]     = ConfigBytes[i][7:4];   // high first
         expNibble[FirstConfigPulse + 2 * i + 1] = ConfigBytes[i][3:0];
         expSelect[FirstConfigPulse + 2 * i]     = 1'b0;
         expSelect[FirstConfigPulse + 2 * i + 1] = 1'b0;
      end
      for (int i = 0; i < lcdPkg::PhraseLength; i++)
      begin
         expNibble[FirstPhrasePulse + 2 * i]     = lcdPkg::PhraseText[i][7:4];
         expNibble[FirstPhrasePulse + 2 * i + 1] = lcdPkg::PhraseText[i][3:0];
         expSelect[FirstPhrasePulse + 2 * i]     = 1'b1;  // data writes
         expSelect[FirstPhrasePulse + 2 * i + 1] = 1'b1;
      end
   end

   task automatic flagError(input string message);
      $display("%s", message);
      errorSeen = 1'b1;
   endtask

   // all outputs quiet
   task automatic checkIdle(input string when);
      assert (lcdEnable == 1'b0)
         else flagError($sformatf("FAIL lcdEnable: got 0x%h expected 0x0 %s", lcdEnable, when));
      assert (lcdRegisterSelect == 1'b0)
         else flagError($sformatf("FAIL lcdRegisterSelect: got 0x%h expected 0x0 %s",
                                  lcdRegisterSelect, when));
      assert (lcdData == 4'h0)
         else flagError($sformatf("FAIL lcdData: got 0x%h expected 0x0 %s", lcdData, when));
      assert (initDone == 1'b0)
         else flagError($sformatf("FAIL initDone: got 0x%h expected 0x0 %s", initDone, when));
   endtask

   task automatic checkRise();
      assert (pulseIndex < PulseCount)
         else flagError("an enable pulse came after the whole sequence");
      if (pulseIndex < PulseCount)
      begin
         assert (lcdData == expNibble[pulseIndex])
            else flagError($sformatf("FAIL lcdData: got 0x%h expected 0x%h at pulse %0d",
                                     lcdData, expNibble[pulseIndex], pulseIndex));
         assert (lcdRegisterSelect == expSelect[pulseIndex])
            else flagError($sformatf("FAIL lcdRegisterSelect: got 0x%h expected 0x%h at pulse %0d",
                                     lcdRegisterSelect, expSelect[pulseIndex], pulseIndex));
      end
      if (pulseIndex == 0)
      begin
         assert (sinceRelease >= PowerOnWait)
            else flagError("first enable pulse came before the power-on wait ended");
      end
      if (pulseIndex == 1)
      begin
         assert (sinceFall >= InitLongWait)
            else flagError("second init nibble came before the long init wait ended");
      end
      if (pulseIndex == FirstPhrasePulse)
      begin
         assert (sinceFall >= ClearWait)
            else flagError("first phrase nibble came before the clear wait ended");
      end
      pulseData   = lcdData;
      pulseSelect = lcdRegisterSelect;
      highCount   = 1;
      pulseIndex++;
   endtask

   task automatic checkSteady(input string when);
      assert (lcdData == pulseData)
         else flagError($sformatf("FAIL lcdData: got 0x%h expected 0x%h %s",
                                  lcdData, pulseData, when));
      assert (lcdRegisterSelect == pulseSelect)
         else flagError($sformatf("FAIL lcdRegisterSelect: got 0x%h expected 0x%h %s",
                                  lcdRegisterSelect, pulseSelect, when));
   endtask

   // --------------------
   // sampled at the rising edge
   // --------------------
   always @(posedge Clock)
   begin
      if (!rstN)
      begin
         checkIdle("in reset");
         pulseIndex   = 0;                               // sequence restarts
         highCount    = 0;
         sinceRelease = 0;
         sinceFall    = 0;
      end
      else
      begin
         if (!prevRstN)
            checkIdle("in the first cycle after reset");
         if (lcdEnable && !prevEnable)
            checkRise();
         else if (lcdEnable)
         begin
            highCount++;
            checkSteady("while lcdEnable is high");
         end
         else if (prevEnable)
         begin
            assert (highCount == EnableCycles)
               else flagError($sformatf("FAIL lcdEnable width: got 0x%h expected 0x%h",
                                        highCount, EnableCycles));
            checkSteady("in the hold cycle");            // held one cycle after fall
            sinceFall = 0;
         end
         else
            sinceFall++;
         if (initDone)
         begin
            assert (pulseIndex == PulseCount)
               else flagError("initDone rose before the last phrase nibble");
            assert (!lcdEnable)
               else flagError("an enable pulse came while initDone was high");
         end
         sinceRelease++;
      end
      prevRstN   = rstN;
      prevEnable = rstN && lcdEnable;
   end

endmodule

`default_nettype wire

// ==== test/lcdTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdTb;

   localparam int EnableCycles = 4;
   localparam int NibbleGap    = 3;
   localparam int CommandWait  = 8;
   localparam int PowerOnWait  = 40;
   localparam int InitLongWait = 20;
   localparam int InitMidWait  = 10;
   localparam int ClearWait    = 30;

   localparam int ClockPeriod = 40;                      // ns
   localparam int DriveDelay  = 2;                       // ns after the rising edge
   localparam int ResetCycles = 10;
   localparam int TailCycles  = 50;                      // quiet time after initDone

   // waits of one full run, 18 writes and 14 nibble gaps
   localparam int WaitSum = PowerOnWait + InitLongWait + InitMidWait + ClearWait +
                            18 * CommandWait + 14 * NibbleGap;
   localparam int WatchdogCycles = 2 * (WaitSum + 32 * (EnableCycles + 2)) +
                                   2 * ResetCycles + TailCycles;

   logic                  Clock;
   logic                  rstN;
   wire lcdPkg::lcdNibbleT lcdData;
   wire                   lcdEnable;
   wire                   lcdRegisterSelect;
   wire                   initDone;
   wire                   checkFailed;
   integer                seed;
   integer                resetOffset;               // cycles into the config bytes

   always #(ClockPeriod / 2) Clock = ~Clock;

   lcdController #(
      .EnableCycles (EnableCycles),
      .NibbleGap    (NibbleGap),
      .CommandWait  (CommandWait),
      .PowerOnWait  (PowerOnWait),
      .InitLongWait (InitLongWait),
      .InitMidWait  (InitMidWait),
      .ClearWait    (ClearWait)
   ) dut (
      .Clock             (Clock),
      .rstN              (rstN),
      .lcdData           (lcdData),
      .lcdEnable         (lcdEnable),
      .lcdRegisterSelect (lcdRegisterSelect),
      .initDone          (initDone)
   );

   lcdBusMonitor #(
      .EnableCycles (EnableCycles),
      .PowerOnWait  (PowerOnWait),
      .InitLongWait (InitLongWait),
      .ClearWait    (ClearWait)
   ) monitor (
      .Clock             (Clock),
      .rstN              (rstN),
      .lcdData           (lcdData),
      .lcdEnable         (lcdEnable),
      .lcdRegisterSelect (lcdRegisterSelect),
      .initDone          (initDone),
      .checkFailed       (checkFailed)
   );

   task automatic stopWithFailure(input string reason);
      $display("ERRORS FOUND");
      $fatal(1, "%s", reason);
   endtask

   // --------------------
   // stimulus
   // --------------------
   initial
   begin
      Clock = 1'b0;
      rstN  = 1'b1;
      seed  = 32'habd9_08bb;
      #DriveDelay rstN = 1'b0;                           // clean falling edge
      repeat (ResetCycles) @(posedge Clock);
      #DriveDelay rstN = 1'b1;
      repeat (4) @(posedge lcdEnable);                   // init nibbles out
      resetOffset = 16 + ($unsigned($random(seed)) % 80); // lands in config bytes
      repeat (resetOffset) @(posedge Clock);
      #DriveDelay rstN = 1'b0;                           // mid-run reset
      repeat (ResetCycles) @(posedge Clock);
      #DriveDelay rstN = 1'b1;
      @(posedge initDone);
      repeat (TailCycles) @(posedge Clock);              // no pulse may follow
      if (checkFailed)
         stopWithFailure("a bus check failed");
      else
      begin
         $display("NO ERRORS");
         $finish;
      end
   end

   // first failing check ends the run
   initial
   begin
      @(posedge checkFailed);
      stopWithFailure("a bus check failed");
   end

   initial
   begin
      repeat (WatchdogCycles) @(posedge Clock);
      stopWithFailure("watchdog expired before initDone and the quiet tail");
   end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/lcdPkg.sv
rtl/lcdNibbleWriter.sv
rtl/lcdSequencer.sv
rtl/lcdController.sv
test/lcdBusMonitor.sv
test/lcdTb.sv
